//--- hw/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Datapath and address width
`define CPU_XLEN 32

// First fetch address after reset
`define CPU_RESET_PC 32'h0000_0000

// Architectural register count, r0 included
`define CPU_NUM_REGS 32

// Scratch CSRs at the bottom of the CSR space
`define CPU_NUM_SCRATCH 4

`endif

//--- hw/cpu_core.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpu_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  imem_req_ready,
    input  logic                  imem_resp_valid,
    input  logic [`CPU_XLEN-1:0]  imem_resp_data,
    output logic                  imem_req_valid,
    output pipe_pkg::imem_req_t   imem_req,
    output pipe_pkg::wb_trace_t   wb_trace,
    output logic                  halted
);

    pipe_pkg::if_id_t     if_id;
    pipe_pkg::id_ex_t     id_ex;
    pipe_pkg::ex_wb_t     ex_wb;
    pipe_pkg::redirect_t  redirect;

    isa_pkg::reg_idx_t    rj_idx;
    isa_pkg::reg_idx_t    rk_idx;
    logic [`CPU_XLEN-1:0] rj_data;
    logic [`CPU_XLEN-1:0] rk_data;

    isa_pkg::csr_addr_e   csr_addr;
    logic                 csr_we;
    logic [`CPU_XLEN-1:0] csr_wr_data;
    logic [`CPU_XLEN-1:0] csr_rd_data;
    logic                 retire;
    logic                 halt;

    fetch u_fetch (
        .clk,
        .arst_n,
        .imem_req_ready,
        .imem_resp_valid,
        .imem_resp_data,
        .redirect,
        .halt,
        .imem_req_valid,
        .imem_req,
        .if_id
    );

    decode u_decode (
        .clk,
        .arst_n,
        .if_id,
        .redirect,
        .rj_data,
        .rk_data,
        .rj_idx,
        .rk_idx,
        .id_ex
    );

    execute u_execute (
        .clk,
        .arst_n,
        .id_ex,
        .csr_rd_data,
        .ex_wb,
        .redirect,
        .csr_addr,
        .csr_we,
        .csr_wr_data,
        .retire
    );

    // Writeback stage is the ex_wb register itself
    reg_file u_reg_file (
        .clk,
        .arst_n,
        .rj_idx,
        .rk_idx,
        .we      (ex_wb.we),
        .wr_idx  (ex_wb.rd),
        .wr_data (ex_wb.result),
        .rj_data,
        .rk_data
    );

    csr_file u_csr_file (
        .clk,
        .arst_n,
        .csr_addr,
        .csr_we,
        .csr_wr_data,
        .retire,
        .csr_rd_data,
        .halt
    );

    assign wb_trace.valid    = ex_wb.valid;
    assign wb_trace.pc       = ex_wb.pc;
    assign wb_trace.rf_we    = ex_wb.we;
    assign wb_trace.rf_wnum  = ex_wb.rd;
    assign wb_trace.rf_wdata = ex_wb.result;

    assign halted = halt;

endmodule

`default_nettype wire

//--- hw/csr_file.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module csr_file (
    input  logic                 clk,
    input  logic                 arst_n,
    input  isa_pkg::csr_addr_e   csr_addr,
    input  logic                 csr_we,
    input  logic [`CPU_XLEN-1:0] csr_wr_data,
    input  logic                 retire,
    output logic [`CPU_XLEN-1:0] csr_rd_data,
    output logic                 halt
);

    localparam int SCR_W = $clog2(`CPU_NUM_SCRATCH);

    logic [`CPU_XLEN-1:0] scratch [`CPU_NUM_SCRATCH];
    logic [`CPU_XLEN-1:0] retired;
    logic [`CPU_XLEN-1:0] ctrl;
    logic [15:0]          scr_off;
    logic                 is_scratch;

    assign scr_off    = csr_addr - isa_pkg::CSR_SCRATCH0;
    assign is_scratch = scr_off < 16'(`CPU_NUM_SCRATCH);

    always_comb begin
        csr_rd_data = '0;
        if (is_scratch) begin
            csr_rd_data = scratch[scr_off[SCR_W-1:0]];
        end else if (csr_addr == isa_pkg::CSR_RETIRED) begin
            csr_rd_data = retired;         // Count before this instruction
        end else if (csr_addr == isa_pkg::CSR_CTRL) begin
            csr_rd_data = ctrl;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU_NUM_SCRATCH; i++) begin
                scratch[i] <= '0;
            end
            retired <= '0;
            ctrl    <= '0;
        end else begin
            retired <= retired + `CPU_XLEN'(retire);
            if (csr_we && is_scratch) begin
                scratch[scr_off[SCR_W-1:0]] <= csr_wr_data;
            end
            if (csr_we && csr_addr == isa_pkg::CSR_CTRL) begin
                ctrl <= csr_wr_data;
            end
        end
    end

    assign halt = ctrl[isa_pkg::CTRL_HALT_BIT];

    // A write to RETIRED lands in no scratch register and leaves CTRL alone
    a_retired_ro: assert property (@(posedge clk) disable iff (!arst_n)
        csr_we && csr_addr == isa_pkg::CSR_RETIRED
        |=> $stable(ctrl) && !$past(is_scratch));

endmodule

`default_nettype wire

//--- hw/decode.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module decode (
    input  logic                 clk,
    input  logic                 arst_n,
    input  pipe_pkg::if_id_t     if_id,
    input  pipe_pkg::redirect_t  redirect,
    input  logic [`CPU_XLEN-1:0] rj_data,
    input  logic [`CPU_XLEN-1:0] rk_data,
    output isa_pkg::reg_idx_t    rj_idx,
    output isa_pkg::reg_idx_t    rk_idx,
    output pipe_pkg::id_ex_t     id_ex
);

    isa_pkg::opcode_e  opcode;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t rk;
    isa_pkg::imm16_t   imm16;
    isa_pkg::alu_op_e  alu_op;
    logic              we;
    logic              is_branch;
    logic              is_csr;
    logic              csr_wr;

    assign opcode = isa_pkg::opcode_e'(if_id.instr[31:26]);
    assign rd     = if_id.instr[25:21];
    assign rj_idx = if_id.instr[20:16];
    assign rk     = if_id.instr[15:11];
    assign imm16  = if_id.instr[15:0];
    assign rk_idx = is_branch ? rd : rk;  // Branches compare rj with rd

    always_comb begin
        alu_op    = isa_pkg::ALU_NOP;    // Unknown opcodes fall through as no-ops
        we        = 1'b0;
        is_branch = 1'b0;
        is_csr    = 1'b0;
        csr_wr    = 1'b0;
        case (opcode)
            isa_pkg::OP_ADD:   {alu_op, we} = {isa_pkg::ALU_ADD, 1'b1};
            isa_pkg::OP_SUB:   {alu_op, we} = {isa_pkg::ALU_SUB, 1'b1};
            isa_pkg::OP_AND:   {alu_op, we} = {isa_pkg::ALU_AND, 1'b1};
            isa_pkg::OP_OR:    {alu_op, we} = {isa_pkg::ALU_OR, 1'b1};
            isa_pkg::OP_XOR:   {alu_op, we} = {isa_pkg::ALU_XOR, 1'b1};
            isa_pkg::OP_SLT:   {alu_op, we} = {isa_pkg::ALU_SLT, 1'b1};
            isa_pkg::OP_ADDI:  {alu_op, we} = {isa_pkg::ALU_ADDI, 1'b1};
            isa_pkg::OP_LUI:   {alu_op, we} = {isa_pkg::ALU_LUI, 1'b1};
            isa_pkg::OP_BEQ:   {alu_op, is_branch} = {isa_pkg::ALU_BEQ, 1'b1};
            isa_pkg::OP_BNE:   {alu_op, is_branch} = {isa_pkg::ALU_BNE, 1'b1};
            isa_pkg::OP_CSRRD: {is_csr, we} = 2'b11;
            isa_pkg::OP_CSRWR: {is_csr, csr_wr, we} = 3'b111;
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (redirect.valid) begin
            id_ex <= '0;                     // Wrong-path instruction
        end else begin
            id_ex.valid     <= if_id.valid;
            id_ex.pc        <= if_id.pc;
            id_ex.alu_op    <= alu_op;
            id_ex.rj_idx    <= rj_idx;
            id_ex.rj_data   <= rj_data;
            id_ex.rk_idx    <= rk_idx;
            id_ex.rk_data   <= rk_data;
            id_ex.imm       <= {{(`CPU_XLEN-16){imm16[15]}}, imm16};
            id_ex.rd        <= rd;
            id_ex.we        <= we & (rd != '0);
            id_ex.is_branch <= is_branch;
            id_ex.is_csr    <= is_csr;
            id_ex.csr_wr    <= csr_wr;
            id_ex.csr_addr  <= isa_pkg::csr_addr_e'(imm16);
        end
    end

endmodule

`default_nettype wire

//--- hw/execute.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module execute (
    input  logic                 clk,
    input  logic                 arst_n,
    input  pipe_pkg::id_ex_t     id_ex,
    input  logic [`CPU_XLEN-1:0] csr_rd_data,
    output pipe_pkg::ex_wb_t     ex_wb,
    output pipe_pkg::redirect_t  redirect,
    output isa_pkg::csr_addr_e   csr_addr,
    output logic                 csr_we,
    output logic [`CPU_XLEN-1:0] csr_wr_data,
    output logic                 retire
);

    logic [`CPU_XLEN-1:0] op_a;
    logic [`CPU_XLEN-1:0] op_b;
    logic [`CPU_XLEN-1:0] alu_res;
    logic                 taken;

    // One-back bypass from the writeback register
    assign op_a = (ex_wb.we && ex_wb.rd == id_ex.rj_idx) ? ex_wb.result : id_ex.rj_data;
    assign op_b = (ex_wb.we && ex_wb.rd == id_ex.rk_idx) ? ex_wb.result : id_ex.rk_data;

    always_comb begin
        case (id_ex.alu_op)
            isa_pkg::ALU_ADD:  alu_res = op_a + op_b;
            isa_pkg::ALU_SUB:  alu_res = op_a - op_b;
            isa_pkg::ALU_AND:  alu_res = op_a & op_b;
            isa_pkg::ALU_OR:   alu_res = op_a | op_b;
            isa_pkg::ALU_XOR:  alu_res = op_a ^ op_b;
            isa_pkg::ALU_SLT:  alu_res = `CPU_XLEN'($signed(op_a) < $signed(op_b));
            isa_pkg::ALU_ADDI: alu_res = op_a + id_ex.imm;
            isa_pkg::ALU_LUI:  alu_res = id_ex.imm << 16;
            default:           alu_res = '0;
        endcase
    end

    assign taken = (id_ex.alu_op == isa_pkg::ALU_BEQ && op_a == op_b)
                || (id_ex.alu_op == isa_pkg::ALU_BNE && op_a != op_b);

    assign redirect.valid  = id_ex.valid & id_ex.is_branch & taken;
    assign redirect.target = id_ex.pc + (id_ex.imm << 2);

    assign csr_addr    = id_ex.csr_addr;
    assign csr_we      = id_ex.valid & id_ex.is_csr & id_ex.csr_wr;
    assign csr_wr_data = op_a;
    assign retire      = id_ex.valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_wb <= '0;
        end else begin
            ex_wb.valid  <= id_ex.valid;
            ex_wb.pc     <= id_ex.pc;
            ex_wb.rd     <= id_ex.rd;
            ex_wb.we     <= id_ex.valid & id_ex.we;
            ex_wb.result <= id_ex.is_csr ? csr_rd_data : alu_res;  // CSR reads return old value
        end
    end

    // A taken branch writes nothing and squashes the slot behind it
    a_redirect_src: assert property (@(posedge clk) disable iff (!arst_n)
        redirect.valid |=> !id_ex.valid && !$past(id_ex.we) && !$past(id_ex.is_csr));

endmodule

`default_nettype wire

//--- hw/fetch.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module fetch (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 imem_req_ready,
    input  logic                 imem_resp_valid,
    input  logic [`CPU_XLEN-1:0] imem_resp_data,
    input  pipe_pkg::redirect_t  redirect,
    input  logic                 halt,
    output logic                 imem_req_valid,
    output pipe_pkg::imem_req_t  imem_req,
    output pipe_pkg::if_id_t     if_id
);

    logic [`CPU_XLEN-1:0] pc;           // Next address to request
    logic [`CPU_XLEN-1:0] fetch_pc;
    logic                 outstanding;
    logic                 stale;        // Live request belongs to the wrong path
    logic                 req_fire;
    logic                 can_issue;
    logic                 resp_take;

    assign req_fire  = imem_req_valid & imem_req_ready;
    assign fetch_pc  = redirect.valid ? redirect.target : pc;
    // One request live at a time, a new one may start as the old response lands
    assign can_issue = ~halt & ~imem_req_valid & (~outstanding | imem_resp_valid);
    assign resp_take = imem_resp_valid & ~stale & ~redirect.valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc             <= `CPU_RESET_PC;
            imem_req_valid <= 1'b0;
            imem_req       <= '0;
            outstanding    <= 1'b0;
            stale          <= 1'b0;
        end else begin
            if (can_issue) begin
                imem_req_valid <= 1'b1;
                imem_req.addr  <= fetch_pc;
                pc             <= fetch_pc + `CPU_XLEN'(4);
            end else begin
                if (req_fire) begin
                    imem_req_valid <= 1'b0;
                end
                if (redirect.valid) begin
                    pc <= redirect.target;
                end
            end

            if (req_fire) begin
                outstanding <= 1'b1;
            end else if (imem_resp_valid) begin
                outstanding <= 1'b0;
            end

            if (redirect.valid) begin
                stale <= imem_req_valid | (outstanding & ~imem_resp_valid);
            end else if (imem_resp_valid) begin
                stale <= 1'b0;
            end
        end
    end

    // Address of the live request doubles as the PC of its response
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            if_id <= '0;
        end else begin
            if_id.valid <= resp_take;
            if_id.pc    <= imem_req.addr;
            if_id.instr <= imem_resp_data;
        end
    end

    a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        imem_req_valid && !imem_req_ready |=> imem_req_valid && $stable(imem_req.addr));

    a_resp_expected: assert property (@(posedge clk) disable iff (!arst_n)
        imem_resp_valid |-> outstanding);

endmodule

`default_nettype wire

//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // Opcode lives in instr[31:26]
    typedef enum logic [5:0] {
        OP_NOP   = 6'h00,
        OP_ADD   = 6'h01,
        OP_SUB   = 6'h02,
        OP_AND   = 6'h03,
        OP_OR    = 6'h04,
        OP_XOR   = 6'h05,
        OP_SLT   = 6'h06,
        OP_ADDI  = 6'h08,
        OP_LUI   = 6'h09,
        OP_BEQ   = 6'h10,        // Compares rj with rd
        OP_BNE   = 6'h11,
        OP_CSRRD = 6'h18,
        OP_CSRWR = 6'h19
    } opcode_e;

    // rd in [25:21], rj in [20:16], rk in [15:11]
    typedef logic [4:0] reg_idx_t;

    // Immediate in [15:0], overlaps rk
    typedef logic [15:0] imm16_t;

    // CSR number is carried in imm16
    typedef enum logic [15:0] {
        CSR_SCRATCH0 = 16'h0000,
        CSR_SCRATCH1 = 16'h0001,
        CSR_SCRATCH2 = 16'h0002,
        CSR_SCRATCH3 = 16'h0003,
        CSR_RETIRED  = 16'h0010, // Read-only
        CSR_CTRL     = 16'h0020
    } csr_addr_e;

    localparam int CTRL_HALT_BIT = 0;

    typedef enum logic [3:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_ADDI,
        ALU_LUI,
        ALU_BEQ,
        ALU_BNE
    } alu_op_e;

endpackage

`default_nettype wire

//--- hw/pipe_pkg.sv
`default_nettype none

`include "cpu_cfg.svh"

package pipe_pkg;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] pc;
        isa_pkg::alu_op_e     alu_op;
        isa_pkg::reg_idx_t    rj_idx;
        logic [`CPU_XLEN-1:0] rj_data;
        isa_pkg::reg_idx_t    rk_idx;     // rd field for branches
        logic [`CPU_XLEN-1:0] rk_data;
        logic [`CPU_XLEN-1:0] imm;        // Sign-extended
        isa_pkg::reg_idx_t    rd;
        logic                 we;
        logic                 is_branch;
        logic                 is_csr;
        logic                 csr_wr;
        isa_pkg::csr_addr_e   csr_addr;
    } id_ex_t;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] pc;
        isa_pkg::reg_idx_t    rd;
        logic                 we;         // Already qualified by valid
        logic [`CPU_XLEN-1:0] result;
    } ex_wb_t;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] target;
    } redirect_t;

    typedef struct packed {
        logic [`CPU_XLEN-1:0] addr;
    } imem_req_t;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] pc;
        logic                 rf_we;
        isa_pkg::reg_idx_t    rf_wnum;
        logic [`CPU_XLEN-1:0] rf_wdata;
    } wb_trace_t;

endpackage

`default_nettype wire

//--- hw/reg_file.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module reg_file (
    input  logic                 clk,
    input  logic                 arst_n,
    input  isa_pkg::reg_idx_t    rj_idx,
    input  isa_pkg::reg_idx_t    rk_idx,
    input  logic                 we,
    input  isa_pkg::reg_idx_t    wr_idx,
    input  logic [`CPU_XLEN-1:0] wr_data,
    output logic [`CPU_XLEN-1:0] rj_data,
    output logic [`CPU_XLEN-1:0] rk_data
);

    logic [`CPU_XLEN-1:0] regs [`CPU_NUM_REGS];
    logic                 wr_ok;

    assign wr_ok = we && (wr_idx != '0);   // r0 stays zero

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_ok) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Same-cycle write is visible to decode
    assign rj_data = (wr_ok && wr_idx == rj_idx) ? wr_data : regs[rj_idx];
    assign rk_data = (wr_ok && wr_idx == rk_idx) ? wr_data : regs[rk_idx];

endmodule

`default_nettype wire

//--- mini_cpu.f
+incdir+hw
hw/isa_pkg.sv
hw/pipe_pkg.sv
hw/fetch.sv
hw/decode.sv
hw/execute.sv
hw/reg_file.sv
hw/csr_file.sv
hw/cpu_core.sv
tests/cpu_core_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module cpu_core_tb -Mdir obj_dir -f mini_cpu.f

out=$(./obj_dir/Vcpu_core_tb 2>&1 || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
    exit 0
fi
exit 1

//--- tests/cpu_core_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpu_core_tb;

    localparam int PROG_LEN    = 32;
    localparam int TRACE_LEN   = 29;
    localparam int IDLE_CYCLES = 20;
    localparam int CYCLE_LIMIT = PROG_LEN * 8 * 2 + 100;  // Covers both runs

    logic                 clk = 1'b0;
    logic                 arst_n;
    logic                 imem_req_ready;
    logic                 imem_resp_valid;
    logic [`CPU_XLEN-1:0] imem_resp_data;
    logic                 imem_req_valid;
    pipe_pkg::imem_req_t  imem_req;
    pipe_pkg::wb_trace_t  wb_trace;
    logic                 halted;

    logic [`CPU_XLEN-1:0] prog [PROG_LEN];
    pipe_pkg::wb_trace_t  exp_trace [TRACE_LEN];

    logic                 pend;             // Accepted request awaiting its response
    logic [`CPU_XLEN-1:0] pend_addr;
    int                   pend_wait;
    integer               seed;
    int                   row;
    int                   cycles = 0;

    cpu_core i_dut (
        .clk,
        .arst_n,
        .imem_req_ready,
        .imem_resp_valid,
        .imem_resp_data,
        .imem_req_valid,
        .imem_req,
        .wb_trace,
        .halted
    );

    initial begin
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT) begin
            $display("Timeout: the program did not finish within %0d cycles", CYCLE_LIMIT);
            $display("FAIL: see errors above");
            $fatal(1, "simulation timed out");
        end
    end

    function automatic logic [31:0] r_type(input isa_pkg::opcode_e op,
                                           input isa_pkg::reg_idx_t rd,
                                           input isa_pkg::reg_idx_t rj,
                                           input isa_pkg::reg_idx_t rk);
        return {op, rd, rj, rk, 11'b0};
    endfunction

    function automatic logic [31:0] i_type(input isa_pkg::opcode_e op,
                                           input isa_pkg::reg_idx_t rd,
                                           input isa_pkg::reg_idx_t rj,
                                           input isa_pkg::imm16_t imm);
        return {op, rd, rj, imm};
    endfunction

    function automatic pipe_pkg::wb_trace_t trace_row(input logic [31:0] pc,
                                                      input logic we,
                                                      input logic [4:0] wnum,
                                                      input logic [31:0] wdata);
        pipe_pkg::wb_trace_t t;
        t.valid    = 1'b1;
        t.pc       = pc;
        t.rf_we    = we;
        t.rf_wnum  = wnum;
        t.rf_wdata = wdata;
        return t;
    endfunction

    // Past the program the memory holds ADDI r31 with a folded address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        logic [15:0] fold;
        fold = addr[31:16] ^ addr[15:0];
        if (addr[31:2] < PROG_LEN) begin
            return prog[addr[6:2]];
        end
        return {isa_pkg::OP_ADDI, 5'd31, 5'd0, fold};
    endfunction

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("FAIL: see errors above");
        $fatal(1, "check failed");
    endtask

    task automatic load_tables();
        prog[0]  = i_type(isa_pkg::OP_ADDI, 5'd1, 5'd0, 16'd5);
        prog[1]  = i_type(isa_pkg::OP_ADDI, 5'd2, 5'd0, 16'hfffa);  // -6
        prog[2]  = r_type(isa_pkg::OP_ADD, 5'd3, 5'd1, 5'd2);
        prog[3]  = r_type(isa_pkg::OP_SUB, 5'd4, 5'd3, 5'd1);
        prog[4]  = r_type(isa_pkg::OP_SLT, 5'd5, 5'd2, 5'd1);
        prog[5]  = r_type(isa_pkg::OP_SLT, 5'd6, 5'd1, 5'd2);
        prog[6]  = i_type(isa_pkg::OP_LUI, 5'd7, 5'd0, 16'h1234);
        prog[7]  = r_type(isa_pkg::OP_OR, 5'd8, 5'd7, 5'd1);
        prog[8]  = r_type(isa_pkg::OP_XOR, 5'd9, 5'd8, 5'd7);
        prog[9]  = r_type(isa_pkg::OP_AND, 5'd10, 5'd8, 5'd2);
        prog[10] = r_type(isa_pkg::OP_ADD, 5'd0, 5'd1, 5'd1);       // Lost in r0
        prog[11] = r_type(isa_pkg::OP_ADD, 5'd11, 5'd0, 5'd1);
        prog[12] = i_type(isa_pkg::OP_BEQ, 5'd2, 5'd1, 16'd3);      // Falls through
        prog[13] = i_type(isa_pkg::OP_BNE, 5'd2, 5'd1, 16'd3);      // To 0x40
        prog[14] = i_type(isa_pkg::OP_ADDI, 5'd12, 5'd0, 16'h0111);
        prog[15] = i_type(isa_pkg::OP_ADDI, 5'd12, 5'd0, 16'h0222);
        prog[16] = i_type(isa_pkg::OP_ADDI, 5'd12, 5'd0, 16'd7);
        prog[17] = i_type(isa_pkg::OP_BEQ, 5'd12, 5'd12, 16'd2);    // To 0x4c
        prog[18] = i_type(isa_pkg::OP_ADDI, 5'd13, 5'd0, 16'h0333);
        prog[19] = i_type(isa_pkg::OP_CSRWR, 5'd14, 5'd1, isa_pkg::CSR_SCRATCH0);
        prog[20] = i_type(isa_pkg::OP_CSRWR, 5'd15, 5'd12, isa_pkg::CSR_SCRATCH0);
        prog[21] = i_type(isa_pkg::OP_CSRRD, 5'd16, 5'd0, isa_pkg::CSR_SCRATCH0);
        prog[22] = i_type(isa_pkg::OP_CSRWR, 5'd17, 5'd3, isa_pkg::CSR_SCRATCH2);
        prog[23] = i_type(isa_pkg::OP_CSRRD, 5'd18, 5'd0, isa_pkg::CSR_SCRATCH2);
        prog[24] = i_type(isa_pkg::OP_CSRRD, 5'd19, 5'd0, isa_pkg::CSR_RETIRED);
        prog[25] = i_type(isa_pkg::OP_CSRWR, 5'd20, 5'd1, isa_pkg::CSR_RETIRED);
        prog[26] = i_type(isa_pkg::OP_CSRRD, 5'd21, 5'd0, isa_pkg::CSR_RETIRED);
        prog[27] = 32'hfc00_0000;                                   // Undefined opcode
        prog[28] = i_type(isa_pkg::OP_NOP, 5'd0, 5'd0, 16'd0);
        prog[29] = i_type(isa_pkg::OP_ADDI, 5'd22, 5'd0, 16'd1);
        prog[30] = i_type(isa_pkg::OP_CSRWR, 5'd0, 5'd22, isa_pkg::CSR_CTRL);
        prog[31] = i_type(isa_pkg::OP_BEQ, 5'd0, 5'd0, 16'd0);      // Spins once halted

        exp_trace[0]  = trace_row(32'h00, 1'b1, 5'd1, 32'h0000_0005);
        exp_trace[1]  = trace_row(32'h04, 1'b1, 5'd2, 32'hffff_fffa);
        exp_trace[2]  = trace_row(32'h08, 1'b1, 5'd3, 32'hffff_ffff);
        exp_trace[3]  = trace_row(32'h0c, 1'b1, 5'd4, 32'hffff_fffa);
        exp_trace[4]  = trace_row(32'h10, 1'b1, 5'd5, 32'h0000_0001);
        exp_trace[5]  = trace_row(32'h14, 1'b1, 5'd6, 32'h0000_0000);
        exp_trace[6]  = trace_row(32'h18, 1'b1, 5'd7, 32'h1234_0000);
        exp_trace[7]  = trace_row(32'h1c, 1'b1, 5'd8, 32'h1234_0005);
        exp_trace[8]  = trace_row(32'h20, 1'b1, 5'd9, 32'h0000_0005);
        exp_trace[9]  = trace_row(32'h24, 1'b1, 5'd10, 32'h1234_0000);
        exp_trace[10] = trace_row(32'h28, 1'b0, 5'd0, 32'h0);
        exp_trace[11] = trace_row(32'h2c, 1'b1, 5'd11, 32'h0000_0005);
        exp_trace[12] = trace_row(32'h30, 1'b0, 5'd0, 32'h0);
        exp_trace[13] = trace_row(32'h34, 1'b0, 5'd0, 32'h0);
        exp_trace[14] = trace_row(32'h40, 1'b1, 5'd12, 32'h0000_0007);
        exp_trace[15] = trace_row(32'h44, 1'b0, 5'd0, 32'h0);
        exp_trace[16] = trace_row(32'h4c, 1'b1, 5'd14, 32'h0000_0000);
        exp_trace[17] = trace_row(32'h50, 1'b1, 5'd15, 32'h0000_0005);
        exp_trace[18] = trace_row(32'h54, 1'b1, 5'd16, 32'h0000_0007);
        exp_trace[19] = trace_row(32'h58, 1'b1, 5'd17, 32'h0000_0000);
        exp_trace[20] = trace_row(32'h5c, 1'b1, 5'd18, 32'hffff_ffff);
        exp_trace[21] = trace_row(32'h60, 1'b1, 5'd19, 32'd21);       // Rows before it
        exp_trace[22] = trace_row(32'h64, 1'b1, 5'd20, 32'd22);
        exp_trace[23] = trace_row(32'h68, 1'b1, 5'd21, 32'd23);
        exp_trace[24] = trace_row(32'h6c, 1'b0, 5'd0, 32'h0);
        exp_trace[25] = trace_row(32'h70, 1'b0, 5'd0, 32'h0);
        exp_trace[26] = trace_row(32'h74, 1'b1, 5'd22, 32'h0000_0001);
        exp_trace[27] = trace_row(32'h78, 1'b0, 5'd0, 32'h0);
        exp_trace[28] = trace_row(32'h7c, 1'b0, 5'd0, 32'h0);
    endtask

    task automatic apply_reset();
        @(negedge clk);
        arst_n          = 1'b0;
        imem_req_ready  = 1'b0;
        imem_resp_valid = 1'b0;
        imem_resp_data  = '0;
        pend            = 1'b0;
        pend_addr       = '0;
        pend_wait       = 0;
        repeat (3) @(negedge clk);
        assert (!imem_req_valid && !wb_trace.valid && !halted)
        else report_error("request, trace or halted is high during reset");
        arst_n = 1'b1;
    endtask

    // Decides at the falling edge what the memory does at the next rising edge
    task automatic drive_memory(input bit random_mode);
        imem_resp_valid = 1'b0;
        imem_resp_data  = '0;
        if (pend) begin
            if (pend_wait == 0) begin
                imem_resp_valid = 1'b1;
                imem_resp_data  = mem_word(pend_addr);
                pend            = 1'b0;
            end else begin
                pend_wait = pend_wait - 1;
            end
        end
        if (pend) begin
            imem_req_ready = 1'b0;
        end else if (random_mode) begin
            imem_req_ready = ($random(seed) & 3) != 0;      // Stall one cycle in four
        end else begin
            imem_req_ready = 1'b1;
        end
        if (imem_req_valid && imem_req_ready) begin
            pend      = 1'b1;
            pend_addr = imem_req.addr;
            pend_wait = random_mode ? ($random(seed) & 3) : 0;
        end
    endtask

    task automatic check_trace();
        pipe_pkg::wb_trace_t exp;
        logic                match;
        if (wb_trace.valid) begin
            exp   = exp_trace[row];
            match = wb_trace.pc == exp.pc && wb_trace.rf_we == exp.rf_we;
            if (exp.rf_we) begin                            // Destination only when written
                match = match && wb_trace.rf_wnum == exp.rf_wnum
                        && wb_trace.rf_wdata == exp.rf_wdata;
            end
            assert (match)
            else report_error($sformatf("row %0d got pc %h we %b r%0d=%h, want pc %h we %b r%0d=%h",
                row, wb_trace.pc, wb_trace.rf_we, wb_trace.rf_wnum, wb_trace.rf_wdata,
                exp.pc, exp.rf_we, exp.rf_wnum, exp.rf_wdata));
            row = row + 1;
        end
    endtask

    task automatic run_program(input bit random_mode);
        logic prev_valid;
        row = 0;
        while (row < TRACE_LEN) begin
            @(negedge clk);
            check_trace();
            drive_memory(random_mode);
        end
        assert (halted) else report_error("halted is low after the last instruction retired");
        prev_valid = imem_req_valid;
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            assert (!wb_trace.valid)
            else report_error($sformatf("extra trace entry at pc %h", wb_trace.pc));
            assert (!imem_req_valid || prev_valid)
            else report_error($sformatf("new fetch of %h while halted", imem_req.addr));
            prev_valid = imem_req_valid;
            drive_memory(random_mode);
        end
    endtask

    initial begin
        seed            = 32'h761f_4886;
        arst_n          = 1'b0;
        imem_req_ready  = 1'b0;
        imem_resp_valid = 1'b0;
        imem_resp_data  = '0;
        pend            = 1'b0;
        pend_addr       = '0;
        pend_wait       = 0;
        row             = 0;
        load_tables();
        apply_reset();
        run_program(1'b0);
        apply_reset();
        run_program(1'b1);      // Same trace under stalls and late responses
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire
